//--- hw/core_mem_pkg.sv
// Shared constants, payload structs, APB structs and enums
// for the cluster memory port.

package core_mem_pkg;

  // Memory map and datapath sizes.
  localparam int unsigned NUM_REGION   = 2;
  localparam int unsigned ADDR_W       = 32;
  localparam int unsigned DATA_W       = 32;
  localparam int unsigned BE_W         = DATA_W / 8;
  localparam int unsigned BANK_WORDS   = 256;
  localparam int unsigned REGION_IDX_W = (NUM_REGION > 1) ? $clog2(NUM_REGION) : 1;
  localparam int unsigned BYTE_OFFS_W  = $clog2(BE_W);  // Byte offset inside a word.
  localparam int unsigned WORD_IDX_W   = $clog2(BANK_WORDS);

  // APB register port.
  localparam int unsigned APB_ADDR_W = 8;
  localparam int unsigned APB_DATA_W = 32;
  localparam int unsigned REG_STRIDE = 4;  // Bytes between per-region registers.

  typedef logic [ADDR_W-1:0]       addr_t;
  typedef logic [DATA_W-1:0]       data_t;
  typedef logic [REGION_IDX_W-1:0] region_idx_t;
  typedef logic [APB_ADDR_W-1:0]   apb_addr_t;
  typedef logic [APB_DATA_W-1:0]   apb_data_t;

  localparam apb_addr_t REG_CTRL       = 8'h00;  // Bit 0 is the port enable.
  localparam apb_addr_t REG_START_BASE = 8'h10;
  localparam apb_addr_t REG_END_BASE   = 8'h20;

  // Response opcode.
  typedef enum logic {
    OPC_OK  = 1'b0,  // A region was hit.
    OPC_ERR = 1'b1   // Address matched no region.
  } rsp_opc_e;

  // Demux response tracking.
  typedef enum logic {
    IDLE     = 1'b0,
    RESPONSE = 1'b1  // A response is owed this cycle.
  } demux_state_e;

  // Core request payload; wen high means read.
  typedef struct packed {
    addr_t           addr;
    logic            wen;
    data_t           data;
    logic [BE_W-1:0] be;
  } core_req_t;

  // Core response payload.
  typedef struct packed {
    data_t    data;
    rsp_opc_e opc;
  } core_rsp_t;

  // APB requester side.
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // APB completer side.
  typedef struct packed {
    logic      pready;
    apb_data_t prdata;
    logic      pslverr;
  } apb_rsp_t;

endpackage

//--- hw/sram_bank.sv
// Single-port word SRAM bank with byte enables and a
// one-cycle registered response.

`timescale 1ns/1ps

module sram_bank (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_valid_i,
  input  core_mem_pkg::core_req_t req_i,
  output logic                    gnt_o,
  output logic                    rsp_valid_o,
  output core_mem_pkg::core_rsp_t rsp_o
);

  core_mem_pkg::data_t                 mem_q [core_mem_pkg::BANK_WORDS];
  logic [core_mem_pkg::WORD_IDX_W-1:0] idx;
  core_mem_pkg::data_t                 wdata_merged;
  core_mem_pkg::data_t                 rdata_q;
  logic                                rsp_valid_q;

  assign gnt_o = req_valid_i;  // Never stalls.

  // Word index, wraps modulo the bank size.
  assign idx = req_i.addr[core_mem_pkg::BYTE_OFFS_W +: core_mem_pkg::WORD_IDX_W];

  always_comb begin : be_merge
    wdata_merged = mem_q[idx];
    for (int unsigned b = 0; b < core_mem_pkg::BE_W; b++) begin
      if (req_i.be[b]) wdata_merged[8*b +: 8] = req_i.data[8*b +: 8];
    end
  end

  always_ff @(posedge clk_i) begin : mem_port
    if (req_valid_i) begin
      rdata_q <= mem_q[idx];  // Old word, also for writes.
      if (!req_i.wen) begin
        mem_q[idx] <= wdata_merged;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : rsp_ff
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_valid_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o.data  = rdata_q;
  assign rsp_o.opc   = core_mem_pkg::OPC_OK;

endmodule

//--- hw/region_cfg_apb.sv
// APB register block: port enable, clear pulse and
// start/end bounds of each memory region.

`timescale 1ns/1ps

module region_cfg_apb (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  core_mem_pkg::apb_req_t                            apb_req_i,
  output core_mem_pkg::apb_rsp_t                            apb_rsp_o,
  output logic                                              enable_o,
  output logic                                              clear_o,
  output core_mem_pkg::addr_t [core_mem_pkg::NUM_REGION-1:0] region_start_o,
  output core_mem_pkg::addr_t [core_mem_pkg::NUM_REGION-1:0] region_end_o
);

  logic                                  access;     // APB access phase.
  logic                                  wr_access;
  logic                                  hit_ctrl;
  logic                                  hit_any;
  logic [core_mem_pkg::NUM_REGION-1:0]   hit_start;
  logic [core_mem_pkg::NUM_REGION-1:0]   hit_end;
  core_mem_pkg::apb_data_t               rdata;
  logic                                  enable_q;
  core_mem_pkg::addr_t [core_mem_pkg::NUM_REGION-1:0] start_q;
  core_mem_pkg::addr_t [core_mem_pkg::NUM_REGION-1:0] end_q;

  assign access    = apb_req_i.psel & apb_req_i.penable;
  assign wr_access = access & apb_req_i.pwrite;
  assign hit_ctrl  = (apb_req_i.paddr == core_mem_pkg::REG_CTRL);

  // Per-region bound offsets.
  always_comb begin : decode
    for (int unsigned i = 0; i < core_mem_pkg::NUM_REGION; i++) begin
      hit_start[i] = (apb_req_i.paddr == core_mem_pkg::apb_addr_t'(
                      core_mem_pkg::REG_START_BASE + core_mem_pkg::REG_STRIDE * i));
      hit_end[i]   = (apb_req_i.paddr == core_mem_pkg::apb_addr_t'(
                      core_mem_pkg::REG_END_BASE + core_mem_pkg::REG_STRIDE * i));
    end
  end

  // Readback; undefined offsets read as zero.
  always_comb begin : read_mux
    rdata   = '0;
    hit_any = hit_ctrl;
    if (hit_ctrl) begin
      rdata = {{(core_mem_pkg::APB_DATA_W-1){1'b0}}, enable_q};
    end
    for (int unsigned i = 0; i < core_mem_pkg::NUM_REGION; i++) begin
      if (hit_start[i]) begin
        rdata   = core_mem_pkg::apb_data_t'(start_q[i]);
        hit_any = 1'b1;
      end
      if (hit_end[i]) begin
        rdata   = core_mem_pkg::apb_data_t'(end_q[i]);
        hit_any = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : regs
    if (!rst_ni) begin
      enable_q <= 1'b0;
      start_q  <= '0;  // All regions start out empty.
      end_q    <= '0;
    end else if (wr_access) begin
      if (hit_ctrl) begin
        enable_q <= apb_req_i.pwdata[0];
      end
      for (int unsigned i = 0; i < core_mem_pkg::NUM_REGION; i++) begin
        if (hit_start[i]) start_q[i] <= core_mem_pkg::addr_t'(apb_req_i.pwdata);
        if (hit_end[i])   end_q[i]   <= core_mem_pkg::addr_t'(apb_req_i.pwdata);
      end
    end
  end

  assign apb_rsp_o.pready  = 1'b1;  // Zero wait states.
  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pslverr = access & ~hit_any;

  // Pulses in the access cycle, so the demux is flushed at the same edge.
  assign clear_o        = wr_access & hit_ctrl;
  assign enable_o       = enable_q;
  assign region_start_o = start_q;
  assign region_end_o   = end_q;

endmodule

//--- hw/mem_demux.sv
// Memory-map demultiplexer: region decode, address rebase,
// request routing, response selection and unmapped-access errors.

`timescale 1ns/1ps

module mem_demux (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic                                                 clear_i,
  input  logic                                                 enable_i,
  input  core_mem_pkg::addr_t     [core_mem_pkg::NUM_REGION-1:0] region_start_i,
  input  core_mem_pkg::addr_t     [core_mem_pkg::NUM_REGION-1:0] region_end_i,
  input  logic                                                 req_valid_i,
  input  core_mem_pkg::core_req_t                              req_i,
  output logic                                                 gnt_o,
  output logic                                                 rsp_valid_o,
  output core_mem_pkg::core_rsp_t                              rsp_o,
  output logic                    [core_mem_pkg::NUM_REGION-1:0] bank_req_valid_o,
  output core_mem_pkg::core_req_t [core_mem_pkg::NUM_REGION-1:0] bank_req_o,
  input  logic                    [core_mem_pkg::NUM_REGION-1:0] bank_gnt_i,
  input  logic                    [core_mem_pkg::NUM_REGION-1:0] bank_rsp_valid_i,
  input  core_mem_pkg::core_rsp_t [core_mem_pkg::NUM_REGION-1:0] bank_rsp_i
);

  core_mem_pkg::demux_state_e state_d, state_q;
  core_mem_pkg::region_idx_t  region_d, region_q;
  logic                       hit;         // Some region matched.
  logic                       unmapped_q;  // Owed response is an error.
  logic                       transfer;

  // Half-open range check, the last match (highest index) wins.
  always_comb begin : decode
    hit      = 1'b0;
    region_d = '0;
    for (int unsigned i = 0; i < core_mem_pkg::NUM_REGION; i++) begin
      if ((req_i.addr >= region_start_i[i]) && (req_i.addr < region_end_i[i])) begin
        hit      = 1'b1;
        region_d = core_mem_pkg::region_idx_t'(i);
      end
    end
  end

  // Every bank sees the payload rebased to its own region start.
  always_comb begin : rebase
    for (int unsigned i = 0; i < core_mem_pkg::NUM_REGION; i++) begin
      bank_req_o[i]      = req_i;
      bank_req_o[i].addr = req_i.addr - region_start_i[i];
    end
  end

  always_comb begin : route
    bank_req_valid_o = '0;
    if (req_valid_i && enable_i && hit) begin
      bank_req_valid_o[region_d] = 1'b1;
    end
  end

  // Unmapped requests are granted here, mapped ones by the bank.
  assign gnt_o    = enable_i & req_valid_i & (hit ? bank_gnt_i[region_d] : 1'b1);
  assign transfer = req_valid_i & gnt_o;

  // At most one response is owed, always in the next cycle.
  assign state_d = transfer ? core_mem_pkg::RESPONSE : core_mem_pkg::IDLE;

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_seq
    if (!rst_ni) begin
      state_q <= core_mem_pkg::IDLE;
    end else if (clear_i) begin
      state_q <= core_mem_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : target_ff
    if (!rst_ni) begin
      region_q   <= '0;
      unmapped_q <= 1'b0;
    end else if (clear_i) begin
      region_q   <= '0;
      unmapped_q <= 1'b0;
    end else if (transfer) begin
      region_q   <= region_d;
      unmapped_q <= ~hit;
    end
  end

  always_comb begin : rsp_sel
    rsp_valid_o = 1'b0;
    rsp_o       = '0;
    rsp_o.opc   = core_mem_pkg::OPC_OK;
    case (state_q)
      core_mem_pkg::RESPONSE: begin
        if (unmapped_q) begin
          rsp_valid_o = 1'b1;
          rsp_o.data  = '0;  // Error carries no data.
          rsp_o.opc   = core_mem_pkg::OPC_ERR;
        end else begin
          rsp_valid_o = bank_rsp_valid_i[region_q];
          rsp_o       = bank_rsp_i[region_q];
        end
      end
      default: begin
        rsp_valid_o = 1'b0;
      end
    endcase
  end

endmodule

//--- hw/core_mem_top.sv
// Cluster memory port top level: APB configuration block,
// memory-map demux and the SRAM banks behind it.

`timescale 1ns/1ps

module core_mem_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  core_mem_pkg::apb_req_t  apb_req_i,
  output core_mem_pkg::apb_rsp_t  apb_rsp_o,
  input  logic                    req_valid_i,
  input  core_mem_pkg::core_req_t req_i,
  output logic                    gnt_o,
  output logic                    rsp_valid_o,
  output core_mem_pkg::core_rsp_t rsp_o
);

  logic                                                  enable;
  logic                                                  clear;
  core_mem_pkg::addr_t     [core_mem_pkg::NUM_REGION-1:0] region_start;
  core_mem_pkg::addr_t     [core_mem_pkg::NUM_REGION-1:0] region_end;
  logic                    [core_mem_pkg::NUM_REGION-1:0] bank_req_valid;
  core_mem_pkg::core_req_t [core_mem_pkg::NUM_REGION-1:0] bank_req;
  logic                    [core_mem_pkg::NUM_REGION-1:0] bank_gnt;
  logic                    [core_mem_pkg::NUM_REGION-1:0] bank_rsp_valid;
  core_mem_pkg::core_rsp_t [core_mem_pkg::NUM_REGION-1:0] bank_rsp;

  region_cfg_apb region_cfg_apb_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .apb_req_i      (apb_req_i),
    .apb_rsp_o      (apb_rsp_o),
    .enable_o       (enable),
    .clear_o        (clear),
    .region_start_o (region_start),
    .region_end_o   (region_end)
  );

  mem_demux mem_demux_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (clear),
    .enable_i         (enable),
    .region_start_i   (region_start),
    .region_end_i     (region_end),
    .req_valid_i      (req_valid_i),
    .req_i            (req_i),
    .gnt_o            (gnt_o),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_o            (rsp_o),
    .bank_req_valid_o (bank_req_valid),
    .bank_req_o       (bank_req),
    .bank_gnt_i       (bank_gnt),
    .bank_rsp_valid_i (bank_rsp_valid),
    .bank_rsp_i       (bank_rsp)
  );

  // One bank per region.
  for (genvar gi = 0; gi < core_mem_pkg::NUM_REGION; gi++) begin : g_bank
    sram_bank sram_bank_inst (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_valid_i (bank_req_valid[gi]),
      .req_i       (bank_req[gi]),
      .gnt_o       (bank_gnt[gi]),
      .rsp_valid_o (bank_rsp_valid[gi]),
      .rsp_o       (bank_rsp[gi])
    );
  end

endmodule

//--- bench/tb_core_mem_checks.svh
// Error counters, typed compare tasks for responses, grants and APB
// responses, and the APB access tasks of the testbench.

  int unsigned mismatch_cnt = 0;
  int unsigned proto_cnt    = 0;  // Missing, unexpected or ungranted transfers.

  task automatic check_rsp(input string name, input core_mem_pkg::core_rsp_t exp_v,
                           input core_mem_pkg::core_rsp_t act_v);
    if (act_v !== exp_v) begin
      mismatch_cnt++;
      $display("MISMATCH %s at %0t: expected data=%h opc=%h, actual data=%h opc=%h",
               name, $time, exp_v.data, exp_v.opc, act_v.data, act_v.opc);
    end
  endtask

  task automatic check_gnt(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      mismatch_cnt++;
      $display("MISMATCH %s at %0t: expected %h, actual %h", name, $time, exp_v, act_v);
    end
  endtask

  task automatic check_apb(input string name, input core_mem_pkg::apb_rsp_t exp_v,
                           input core_mem_pkg::apb_rsp_t act_v);
    string exp_s;
    string act_s;
    if (act_v !== exp_v) begin
      mismatch_cnt++;
      exp_s = $sformatf("pready=%h prdata=%h pslverr=%h",
                        exp_v.pready, exp_v.prdata, exp_v.pslverr);
      act_s = $sformatf("pready=%h prdata=%h pslverr=%h",
                        act_v.pready, act_v.prdata, act_v.pslverr);
      $display("MISMATCH %s at %0t: expected %s, actual %s", name, $time, exp_s, act_s);
    end
  endtask

  // Setup and access phase. The response is checked in the middle of the access cycle.
  task automatic apb_access(input bit write, input core_mem_pkg::apb_addr_t addr,
                            input core_mem_pkg::apb_data_t data);
    core_mem_pkg::apb_rsp_t exp_v;
    exp_v = reg_expect(addr);
    @(posedge clk_i);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= data;
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    @(negedge clk_i);
    check_apb("apb_rsp_o", exp_v, apb_rsp);
    @(posedge clk_i);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    if (write) reg_update(addr, data);  // Register takes the value at this edge.
  endtask

  task automatic apb_write(input core_mem_pkg::apb_addr_t addr,
                           input core_mem_pkg::apb_data_t data);
    apb_access(1'b1, addr, data);
  endtask

  task automatic apb_read(input core_mem_pkg::apb_addr_t addr);
    apb_access(1'b0, addr, '0);
  endtask

//--- bench/tb_core_mem.sv
// Testbench for the cluster memory port: clock, reset, random stimulus,
// reference model of the register map and banks, and a watchdog.

`timescale 1ns/1ps

module tb_core_mem;

  localparam int unsigned NR       = core_mem_pkg::NUM_REGION;
  localparam int unsigned N_SWEEP  = NR * core_mem_pkg::BANK_WORDS;
  localparam int unsigned N_DIS    = 4;
  localparam int unsigned DIS_WAIT = 8;  // Cycles a request is held while disabled.
  localparam int unsigned N_RAND   = 300;
  localparam int unsigned N_B2B    = 32;
  localparam int unsigned N_UNMAP  = 40;
  localparam int unsigned N_OVL    = 100;
  localparam int unsigned N_APB    = 48;
  localparam int unsigned N_CORE   = 3 * N_SWEEP + N_DIS + N_RAND + N_B2B + N_UNMAP + 2 * N_OVL;
  localparam int unsigned WATCHDOG_CYCLES = (N_APB + N_CORE) * 4 + 1000;
  localparam int unsigned GNT_TIMEOUT     = 4;

  logic                    clk_i;
  logic                    rst_ni;
  core_mem_pkg::apb_req_t  apb_req;
  core_mem_pkg::apb_rsp_t  apb_rsp;
  logic                    req_valid_i;
  core_mem_pkg::core_req_t req_i;
  logic                    gnt_o;
  logic                    rsp_valid_o;
  core_mem_pkg::core_rsp_t rsp_o;
  integer                  seed;

  // Model state. A word is known once it has been fully written.
  logic                    model_enable;
  core_mem_pkg::addr_t     model_start [NR];
  core_mem_pkg::addr_t     model_end   [NR];
  core_mem_pkg::data_t     model_mem   [NR][core_mem_pkg::BANK_WORDS];
  bit                      model_known [NR][core_mem_pkg::BANK_WORDS];
  core_mem_pkg::core_rsp_t exp_q[$];
  bit                      known_q[$];

  `include "tb_core_mem_checks.svh"

  core_mem_top core_mem_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .apb_req_i   (apb_req),
    .apb_rsp_o   (apb_rsp),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .gnt_o       (gnt_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Offset 0 is the control register, then all starts, then all ends.
  function automatic core_mem_pkg::apb_addr_t reg_offs(input int unsigned sel);
    if (sel == 0) return core_mem_pkg::REG_CTRL;
    if (sel <= NR) return core_mem_pkg::apb_addr_t'(core_mem_pkg::REG_START_BASE + 4 * (sel - 1));
    return core_mem_pkg::apb_addr_t'(core_mem_pkg::REG_END_BASE + 4 * (sel - 1 - NR));
  endfunction

  function automatic core_mem_pkg::apb_rsp_t reg_expect(input core_mem_pkg::apb_addr_t addr);
    core_mem_pkg::apb_rsp_t rsp;
    rsp.pready  = 1'b1;
    rsp.prdata  = '0;
    rsp.pslverr = (addr != core_mem_pkg::REG_CTRL);
    if (addr == core_mem_pkg::REG_CTRL) rsp.prdata = core_mem_pkg::apb_data_t'(model_enable);
    for (int unsigned i = 0; i < NR; i++) begin
      if (addr == reg_offs(1 + i)) begin
        rsp.prdata  = model_start[i];
        rsp.pslverr = 1'b0;
      end
      if (addr == reg_offs(1 + NR + i)) begin
        rsp.prdata  = model_end[i];
        rsp.pslverr = 1'b0;
      end
    end
    return rsp;
  endfunction

  task automatic reg_update(input core_mem_pkg::apb_addr_t addr,
                            input core_mem_pkg::apb_data_t data);
    if (addr == core_mem_pkg::REG_CTRL) model_enable = data[0];
    for (int unsigned i = 0; i < NR; i++) begin
      if (addr == reg_offs(1 + i)) model_start[i] = data;
      if (addr == reg_offs(1 + NR + i)) model_end[i] = data;
    end
  endtask

  // Highest matching region wins; no match is an error with zero data.
  task automatic model_access(input core_mem_pkg::core_req_t req);
    core_mem_pkg::core_rsp_t rsp;
    core_mem_pkg::addr_t     offs;
    bit                      hit;
    bit                      known;
    int unsigned             r;
    int unsigned             w;
    hit      = 1'b0;
    r        = 0;
    rsp.data = '0;
    rsp.opc  = core_mem_pkg::OPC_ERR;
    known    = 1'b1;
    for (int unsigned i = 0; i < NR; i++) begin
      if (req.addr >= model_start[i] && req.addr < model_end[i]) begin
        hit = 1'b1;
        r   = i;
      end
    end
    if (hit) begin
      offs     = req.addr - model_start[r];
      w        = (offs >> 2) % core_mem_pkg::BANK_WORDS;
      rsp.data = model_mem[r][w];  // Old word is returned for writes too.
      rsp.opc  = core_mem_pkg::OPC_OK;
      known    = model_known[r][w];
      if (!req.wen) begin
        for (int unsigned b = 0; b < 4; b++) begin
          if (req.be[b]) model_mem[r][w][8*b +: 8] = req.data[8*b +: 8];
        end
        if (req.be == 4'hf) model_known[r][w] = 1'b1;
      end
    end
    exp_q.push_back(rsp);
    known_q.push_back(known);
  endtask

  // Checks the response owed from the last cycle, then records a new transfer.
  always @(negedge clk_i) begin : monitor
    core_mem_pkg::core_rsp_t exp_rsp;
    core_mem_pkg::core_rsp_t act_rsp;
    bit                      known;
    if (rst_ni) begin
      if (rsp_valid_o && exp_q.size() == 0) begin
        proto_cnt++;
        $display("Response arrived at %0t with no request outstanding", $time);
      end else if (exp_q.size() != 0) begin
        exp_rsp = exp_q.pop_front();
        known   = known_q.pop_front();
        act_rsp = rsp_o;
        if (!known) begin
          exp_rsp.data = '0;  // Never-written word has no defined contents.
          act_rsp.data = '0;
        end
        if (rsp_valid_o) begin
          check_rsp("rsp_o", exp_rsp, act_rsp);
        end else begin
          proto_cnt++;
          $display("Expected response missing at %0t", $time);
        end
      end
      if (req_valid_i && gnt_o) model_access(req_i);
    end
  end

  task automatic issue(input core_mem_pkg::core_req_t req);
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i       <= req;
    @(negedge clk_i);
    check_gnt("gnt_o", 1'b1, gnt_o);  // Banks never stall.
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) begin
      @(posedge clk_i);
      req_valid_i <= 1'b0;
    end
  endtask

  task automatic drain();
    idle(1);
    repeat (2) @(negedge clk_i);
  endtask

  task automatic wait_gnt();
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (!gnt_o && n < GNT_TIMEOUT) begin
      n++;
      @(negedge clk_i);
    end
    if (!gnt_o) begin
      proto_cnt++;
      $display("Held request was not granted within %0d cycles", GNT_TIMEOUT);
    end
  endtask

  task automatic span_addr(input core_mem_pkg::addr_t base, input int unsigned words,
                           output core_mem_pkg::addr_t addr);
    logic [31:0] rnd;
    rnd  = $random(seed);
    addr = base + ((rnd % words) << 2);
  endtask

  task automatic rand_payload(input core_mem_pkg::addr_t addr,
                              output core_mem_pkg::core_req_t req);
    logic [31:0] rnd;
    rnd      = $random(seed);
    req.addr = addr;
    req.wen  = rnd[0];
    req.be   = rnd[7:4];
    req.data = $random(seed);
  endtask

  task automatic region_req(input int unsigned r, output core_mem_pkg::core_req_t req);
    core_mem_pkg::addr_t addr;
    span_addr(model_start[r], (model_end[r] - model_start[r]) >> 2, addr);
    rand_payload(addr, req);
  endtask

  // Accesses every word of every region and alternates between banks.
  task automatic sweep(input bit write);
    core_mem_pkg::core_req_t req;
    for (int unsigned w = 0; w < core_mem_pkg::BANK_WORDS; w++) begin
      for (int unsigned r = 0; r < NR; r++) begin
        rand_payload(model_start[r] + 4 * w, req);
        req.wen  = ~write;
        req.be   = 4'hf;
        req.data = req.addr ^ {req.addr[15:0], req.addr[31:16]} ^ 32'h5a5a_c3c3;
        issue(req);
      end
    end
    drain();
  endtask

  initial begin : stimulus
    core_mem_pkg::core_req_t req;
    core_mem_pkg::addr_t     addr;
    logic [31:0]             rnd;
    seed         = 32'hecf0_f075;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    apb_req      = '0;
    model_enable = 1'b0;
    for (int unsigned r = 0; r < NR; r++) begin
      model_start[r] = '0;
      model_end[r]   = '0;
      for (int unsigned w = 0; w < core_mem_pkg::BANK_WORDS; w++) model_known[r][w] = 1'b0;
    end
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Register readback and undefined offsets.
    for (int unsigned s = 0; s <= 2 * NR; s++) apb_read(reg_offs(s));
    apb_read(8'h04);
    apb_read(8'h30);
    apb_read(8'hfc);
    apb_write(8'h08, $random(seed));
    for (int k = 0; k < 8; k++) begin
      rnd = $random(seed);
      apb_write(reg_offs(rnd % (1 + 2 * NR)), $random(seed));
      apb_read(reg_offs(rnd % (1 + 2 * NR)));
    end
    for (int unsigned s = 0; s <= 2 * NR; s++) apb_read(reg_offs(s));

    // Disjoint regions of one bank each with gaps between them.
    apb_write(core_mem_pkg::REG_CTRL, 32'h0);
    for (int unsigned i = 0; i < NR; i++) begin
      apb_write(reg_offs(1 + i), 32'h1000 * (i + 1));
      apb_write(reg_offs(1 + NR + i), 32'h1000 * (i + 1) + 32'h400);
    end
    apb_write(core_mem_pkg::REG_CTRL, 32'h1);
    sweep(1'b1);  // Fill every word.
    apb_write(core_mem_pkg::REG_CTRL, 32'h0);

    // Disabled port; the last request stays held until enable is set.
    for (int unsigned i = 0; i < N_DIS; i++) begin
      rnd = $random(seed);
      region_req(rnd % NR, req);
      @(posedge clk_i);
      req_valid_i <= 1'b1;
      req_i       <= req;
      repeat (DIS_WAIT) begin
        @(negedge clk_i);
        check_gnt("gnt_o", 1'b0, gnt_o);
      end
      if (i != N_DIS - 1) idle(1);
    end
    apb_write(core_mem_pkg::REG_CTRL, 32'h1);
    wait_gnt();
    drain();

    for (int unsigned i = 0; i < N_RAND; i++) begin
      rnd = $random(seed);
      region_req(rnd % NR, req);
      issue(req);
      if (rnd[9:8] == 2'b00) idle(rnd[10] ? 2 : 1);
    end
    for (int unsigned i = 0; i < N_B2B; i++) begin
      region_req(i % NR, req);
      issue(req);
    end
    drain();

    // Below, between, at the end of and above the regions.
    for (int unsigned i = 0; i < N_UNMAP; i++) begin
      case (i % 5)
        0: span_addr(32'h0, 32'h400, addr);
        1: span_addr(model_end[0], (model_start[1] - model_end[0]) >> 2, addr);
        2: addr = model_end[i % NR];
        3: span_addr(model_end[NR-1], 32'h10000, addr);
        default: span_addr(32'hffff_ff00, 64, addr);
      endcase
      rand_payload(addr, req);
      issue(req);
    end
    drain();
    sweep(1'b0);

    // Region 1 overlaps region 0, then both starts move and region 0 wraps.
    apb_write(reg_offs(2), 32'h1200);
    apb_write(reg_offs(2 + NR), 32'h1600);
    for (int unsigned i = 0; i < N_OVL; i++) begin
      span_addr(32'h1000, 32'h180, addr);
      rand_payload(addr, req);
      issue(req);
    end
    drain();
    apb_write(reg_offs(1), 32'h0800);
    apb_write(reg_offs(2), 32'h1100);
    apb_write(reg_offs(2 + NR), 32'h1500);
    for (int unsigned i = 0; i < N_OVL; i++) begin
      span_addr(32'h0800, 32'h340, addr);
      rand_payload(addr, req);
      issue(req);
    end
    drain();
    sweep(1'b0);

    if (exp_q.size() != 0) begin
      proto_cnt++;
      $display("Responses still outstanding at the end of the run");
    end
    $display("Errors: %0d mismatches, %0d protocol errors", mismatch_cnt, proto_cnt);
    if (mismatch_cnt == 0 && proto_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
    $display("Errors: %0d mismatches, %0d protocol errors", mismatch_cnt, proto_cnt);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- all.f
+incdir+bench
hw/core_mem_pkg.sv
hw/sram_bank.sv
hw/region_cfg_apb.sv
hw/mem_demux.sv
hw/core_mem_top.sv
bench/tb_core_mem.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log
# for the pass message.

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_core_mem -f all.f -o tb_core_mem > build.log 2>&1 \
  && ./obj_dir/tb_core_mem > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log

grep -q "^All tests passed$" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
